// ==== include/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// first fetch address out of reset
`define FETCH_RESET_PC 32'h1c000000

// stale response counter width
`define FETCH_DISCARD_W 2

// exception codes
`define FETCH_ECODE_ADEF 6'h08
`define FETCH_ECODE_INE 6'h0d

`endif

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // 3R format used by add.w and friends
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_r3_t;

    // 2R plus 12-bit immediate
    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } inst_ri12_t;

    typedef union packed {
        inst_r3_t   r3;
        inst_ri12_t ri12;
    } inst_word_u;

    typedef enum logic [1:0] {
        OP_ADD_W  = 2'd0,
        OP_ADDI_W = 2'd1,
        OP_NONE   = 2'd2
    } dec_op_e;

    localparam logic [16:0] OPC_ADD_W  = 17'h00020;
    localparam logic [9:0]  OPC_ADDI_W = 10'h00a;

endpackage

`default_nettype wire

// ==== src/fetch_req.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_req (
    input  wire        clk,
    input  wire        rst,
    input  wire        redirect,
    input  wire [31:0] redirect_pc,
    output wire        inst_req,
    output wire [31:0] inst_addr,
    input  wire        inst_addr_ok,
    output wire        req_valid,
    output wire [31:0] req_pc,
    output wire        req_exc,
    input  wire        wait_ready
);
    logic        pc_valid;
    logic [31:0] pc;
    logic        aligned;
    logic        addr_hs;
    logic        xfer;

    assign aligned = pc[1:0] == 2'b00;

    // a redirect pulls back a request memory has not taken yet
    assign inst_req  = pc_valid && aligned && wait_ready && !redirect;
    assign inst_addr = pc;
    assign addr_hs   = inst_req && inst_addr_ok;

    // misaligned pc skips memory and goes down as an ADEF entry
    assign req_valid = pc_valid && (addr_hs || !aligned);
    assign req_pc    = pc;
    assign req_exc   = !aligned;
    assign xfer      = req_valid && wait_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_valid <= 1'b0;
            pc       <= `FETCH_RESET_PC;
        end else begin
            // live from the first edge out of reset
            pc_valid <= 1'b1;
            if (redirect) begin
                pc <= redirect_pc;
            end else if (xfer) begin
                pc <= pc + 32'd4;
            end
        end
    end

    // SRAM-like rule holds the address until it is taken
    addr_hold: assert property (@(posedge clk) disable iff (rst)
        inst_req && !inst_addr_ok && !redirect |=>
            (inst_req || redirect) && $stable(inst_addr));

endmodule

`default_nettype wire

// ==== src/inst_wait.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module inst_wait (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   redirect,
    input  wire                   req_valid,
    input  wire [31:0]            req_pc,
    input  wire                   req_exc,
    output wire                   wait_ready,
    input  wire                   inst_addr_ok,
    input  wire                   inst_data_ok,
    input  wire [31:0]            inst_rdata,
    output wire                   wait_valid,
    output wire [31:0]            wait_pc,
    output fetch_pkg::inst_word_u wait_inst,
    output wire                   wait_exc,
    input  wire                   dec_ready
);
    import fetch_pkg::*;

    localparam logic [`FETCH_DISCARD_W-1:0] DISCARD_ONE =
        {{(`FETCH_DISCARD_W-1){1'b0}}, 1'b1};
    localparam logic [`FETCH_DISCARD_W-1:0] DISCARD_FULL = {`FETCH_DISCARD_W{1'b1}};

    logic                        ent_valid;
    logic                        ent_pend;
    logic                        ent_exc;
    logic [31:0]                 ent_pc;
    inst_word_u                  ent_inst;
    logic [`FETCH_DISCARD_W-1:0] discard;
    logic                        accept;
    logic                        leave;
    logic                        data_fresh;
    logic                        data_stale;
    logic                        stale_inc;

    // entry is done once its word is in, or right away for ADEF
    assign wait_valid = ent_valid && !ent_pend;
    assign wait_pc    = ent_pc;
    assign wait_inst  = ent_inst;
    assign wait_exc   = ent_exc;

    assign leave = wait_valid && dec_ready;

    // no new request while the stale counter is full
    assign wait_ready = (!ent_valid || leave) && (discard != DISCARD_FULL);
    assign accept     = req_valid && wait_ready;

    // responses return in order, so stale ones always come first
    assign data_stale = inst_data_ok && (discard != '0);
    assign data_fresh = inst_data_ok && (discard == '0) && ent_pend;

    // flushed entry still owed a response
    assign stale_inc = redirect && ent_pend && !data_fresh;

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_valid <= 1'b0;
            ent_pend  <= 1'b0;
        end else if (redirect) begin
            ent_valid <= 1'b0;
            ent_pend  <= 1'b0;
        end else if (accept) begin
            ent_valid <= 1'b1;
            ent_pend  <= !req_exc;
        end else if (data_fresh) begin
            ent_pend <= 1'b0;
        end else if (leave) begin
            ent_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ent_pc  <= req_pc;
            ent_exc <= req_exc;
        end
        // word stays here until decode takes it
        if (data_fresh) begin
            ent_inst <= inst_rdata;
        end
    end

    // redirect and swallowed response on one edge cancel
    always_ff @(posedge clk) begin
        if (rst) begin
            discard <= '0;
        end else if (stale_inc && !data_stale) begin
            discard <= discard + DISCARD_ONE;
        end else if (data_stale && !stale_inc) begin
            discard <= discard - DISCARD_ONE;
        end
    end

    discard_no_overflow: assert property (@(posedge clk) disable iff (rst)
        stale_inc && !data_stale |-> discard != DISCARD_FULL);

    // every response must be owed to someone
    data_ok_owed: assert property (@(posedge clk) disable iff (rst)
        inst_data_ok |-> (discard != '0) || ent_pend);

    // aligned entries only arrive with the address handshake
    accept_on_addr_ok: assert property (@(posedge clk) disable iff (rst)
        accept && !req_exc |-> inst_addr_ok);

endmodule

`default_nettype wire

// ==== src/inst_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module inst_decode (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        redirect,
    input  wire                        wait_valid,
    input  wire [31:0]                 wait_pc,
    input  wire fetch_pkg::inst_word_u wait_inst,
    input  wire                        wait_exc,
    output wire                        dec_ready,
    output logic                       out_valid,
    output logic [31:0]                out_pc,
    output fetch_pkg::dec_op_e         out_op,
    output logic [4:0]                 out_rd,
    output logic [4:0]                 out_rj,
    output logic [4:0]                 out_rk,
    output logic [31:0]                out_imm,
    output logic                       out_exc,
    output logic [5:0]                 out_ecode,
    input  wire                        out_ready
);
    import fetch_pkg::*;

    dec_op_e     op_n;
    logic [4:0]  rd_n;
    logic [4:0]  rj_n;
    logic [4:0]  rk_n;
    logic [31:0] imm_n;
    logic        exc_n;
    logic [5:0]  ecode_n;
    logic        take;

    assign dec_ready = !out_valid || out_ready;
    assign take      = wait_valid && dec_ready;

    always_comb begin
        // default is an unknown encoding
        op_n    = OP_NONE;
        rd_n    = wait_inst.r3.rd;
        rj_n    = wait_inst.r3.rj;
        rk_n    = 5'd0;
        imm_n   = 32'd0;
        exc_n   = 1'b1;
        ecode_n = `FETCH_ECODE_INE;
        if (wait_exc) begin
            // no word was fetched
            rd_n    = 5'd0;
            rj_n    = 5'd0;
            ecode_n = `FETCH_ECODE_ADEF;
        end else if (wait_inst.r3.opcode == OPC_ADD_W) begin
            op_n    = OP_ADD_W;
            rk_n    = wait_inst.r3.rk;
            exc_n   = 1'b0;
            ecode_n = 6'h00;
        end else if (wait_inst.ri12.opcode == OPC_ADDI_W) begin
            op_n    = OP_ADDI_W;
            imm_n   = {{20{wait_inst.ri12.imm12[11]}}, wait_inst.ri12.imm12};
            exc_n   = 1'b0;
            ecode_n = 6'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (redirect) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_pc    <= wait_pc;
            out_op    <= op_n;
            out_rd    <= rd_n;
            out_rj    <= rj_n;
            out_rk    <= rk_n;
            out_imm   <= imm_n;
            out_exc   <= exc_n;
            out_ecode <= ecode_n;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend (
    input  wire                clk,
    input  wire                rst,
    input  wire                redirect,
    input  wire [31:0]         redirect_pc,
    output wire                inst_req,
    output wire [31:0]         inst_addr,
    input  wire                inst_addr_ok,
    input  wire                inst_data_ok,
    input  wire [31:0]         inst_rdata,
    output wire                out_valid,
    output wire [31:0]         out_pc,
    output fetch_pkg::dec_op_e out_op,
    output wire [4:0]          out_rd,
    output wire [4:0]          out_rj,
    output wire [4:0]          out_rk,
    output wire [31:0]         out_imm,
    output wire                out_exc,
    output wire [5:0]          out_ecode,
    input  wire                out_ready
);
    import fetch_pkg::*;

    wire        req_valid;
    wire [31:0] req_pc;
    wire        req_exc;
    wire        wait_ready;
    wire        wait_valid;
    wire [31:0] wait_pc;
    inst_word_u wait_inst;
    wire        wait_exc;
    wire        dec_ready;

    fetch_req u_fetch_req (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .inst_addr_ok (inst_addr_ok),
        .req_valid    (req_valid),
        .req_pc       (req_pc),
        .req_exc      (req_exc),
        .wait_ready   (wait_ready)
    );

    inst_wait u_inst_wait (
        .clk          (clk),
        .rst          (rst),
        .redirect     (redirect),
        .req_valid    (req_valid),
        .req_pc       (req_pc),
        .req_exc      (req_exc),
        .wait_ready   (wait_ready),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .wait_valid   (wait_valid),
        .wait_pc      (wait_pc),
        .wait_inst    (wait_inst),
        .wait_exc     (wait_exc),
        .dec_ready    (dec_ready)
    );

    inst_decode u_inst_decode (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .wait_valid (wait_valid),
        .wait_pc    (wait_pc),
        .wait_inst  (wait_inst),
        .wait_exc   (wait_exc),
        .dec_ready  (dec_ready),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_op     (out_op),
        .out_rd     (out_rd),
        .out_rj     (out_rj),
        .out_rk     (out_rk),
        .out_imm    (out_imm),
        .out_exc    (out_exc),
        .out_ecode  (out_ecode),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// ==== tests/tb_fetch_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch_frontend;
    import fetch_pkg::*;

    logic        clk;
    logic        rst;
    logic        redirect;
    logic [31:0] redirect_pc;
    wire         inst_req;
    wire  [31:0] inst_addr;
    logic        inst_addr_ok;
    logic        inst_data_ok;
    logic [31:0] inst_rdata;
    wire         out_valid;
    wire  [31:0] out_pc;
    dec_op_e     out_op;
    wire  [4:0]  out_rd;
    wire  [4:0]  out_rj;
    wire  [4:0]  out_rk;
    wire  [31:0] out_imm;
    wire         out_exc;
    wire  [5:0]  out_ecode;
    logic        out_ready;

    logic [31:0] rng;
    logic [31:0] exp_pc;
    logic [31:0] mem_addr[$];
    int          mem_due[$];
    int          errors;
    int          checked;
    int          cycle;
    int          idle;
    int          held_reqs;
    int          seen_adef;
    int          seen_ine;
    logic        hold;
    logic        was_stalled;
    logic [88:0] held_out;

    wire [88:0] out_all = {out_valid, out_pc, out_op, out_rd, out_rj, out_rk, out_imm,
                           out_exc, out_ecode};

    fetch_frontend dut (.*);

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // memory contents hashed from the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = (addr ^ 32'h5bd1e995) * 32'h9e3779b1;
        h = h ^ (h >> 15);
        case (h[31:30])
            2'd0: return {OPC_ADD_W, h[14:0]};
            2'd3: return {1'b1, h[30:0]};
            default: return {OPC_ADDI_W, h[21:0]};
        endcase
    endfunction

    task automatic check_output();
        logic [31:0] w;
        logic [88:0] want;
        w = mem_word(exp_pc);
        if (exp_pc[1:0] != 2'b00) begin
            want = {1'b1, exp_pc, OP_NONE, 15'd0, 32'd0, 1'b1, `FETCH_ECODE_ADEF};
            seen_adef++;
        end else if (w[31:15] == OPC_ADD_W) begin
            want = {1'b1, exp_pc, OP_ADD_W, w[4:0], w[9:5], w[14:10], 32'd0, 1'b0, 6'h00};
        end else if (w[31:22] == OPC_ADDI_W) begin
            want = {1'b1, exp_pc, OP_ADDI_W, w[4:0], w[9:5], 5'd0,
                    {{20{w[21]}}, w[21:10]}, 1'b0, 6'h00};
        end else begin
            want = {1'b1, exp_pc, OP_NONE, w[4:0], w[9:5], 5'd0, 32'd0, 1'b1,
                    `FETCH_ECODE_INE};
            seen_ine++;
        end
        if (out_pc != exp_pc) begin
            $display("[ERROR] pc_order: expected %h, actual %h", exp_pc, out_pc);
            errors++;
        end else if (out_all != want) begin
            $display("[ERROR] decode at %h: expected %h, actual %h", exp_pc, want, out_all);
            errors++;
        end
        checked++;
        exp_pc = exp_pc + 32'd4;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [31:0] t;
        r = next_rand();
        t = next_rand();
        redirect = 1'b0;
        // cycle 2000 starts the back-pressure window from a known target
        if (cycle == 2000 || (!hold && r[31:24] < 8'd10)) begin
            redirect = 1'b1;
            redirect_pc = (cycle == 2000) ? 32'h1c008000 : {16'h1c00, t[15:2], 2'b00};
            if (cycle != 2000 && t[18:16] == 3'd0) begin
                redirect_pc[1:0] = (t[20:19] == 2'b00) ? 2'b10 : t[20:19];
            end
        end
        out_ready = !hold && (r[23:16] < 8'd179);
        inst_addr_ok = r[15:14] != 2'b00;
        inst_data_ok = 1'b0;
        inst_rdata = t;
        if (mem_due.size() > 0 && mem_due[0] <= cycle) begin
            inst_data_ok = 1'b1;
            inst_rdata = mem_word(mem_addr.pop_front());
            void'(mem_due.pop_front());
        end
    endtask

    task automatic sample_cycle();
        if (was_stalled && out_all != held_out) begin
            $display("[ERROR] hold_stable: expected %h, actual %h", held_out, out_all);
            errors++;
        end
        was_stalled = out_valid && !out_ready && !redirect;
        held_out = out_all;
        idle++;
        if (out_valid && out_ready) begin
            check_output();
            idle = 0;
        end
        if (redirect) begin
            exp_pc = redirect_pc;
        end
        if (inst_req && inst_addr_ok) begin
            if (inst_addr[1:0] != 2'b00) begin
                $display("memory accepted a request for misaligned address %h", inst_addr);
                errors++;
            end
            mem_addr.push_back(inst_addr);
            mem_due.push_back(cycle + 1 + int'(next_rand() >> 30));
            if (hold) begin
                held_reqs++;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rng = 32'h82e4bddd;
        rst = 1'b1;
        redirect = 1'b0;
        redirect_pc = 32'd0;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        inst_rdata = 32'd0;
        out_ready = 1'b0;
        errors = 0;
        checked = 0;
        idle = 0;
        held_reqs = 0;
        seen_adef = 0;
        seen_ine = 0;
        hold = 1'b0;
        was_stalled = 1'b0;
        held_out = '0;
        exp_pc = `FETCH_RESET_PC;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // stops early if outputs stop flowing
        for (cycle = 0; cycle < 3000 && idle < 200; cycle++) begin
            hold = cycle > 2000 && cycle <= 2040;
            drive_inputs();
            @(negedge clk);
            sample_cycle();
            if (cycle == 2040 && held_reqs > 3) begin
                $display("[ERROR] hold_requests: expected at most 3, actual %0d", held_reqs);
                errors++;
            end
            if (cycle == 2040 && !out_valid) begin
                $display("no output became valid while out_ready was held low");
                errors++;
            end
            @(posedge clk);
            #1;
        end
        if (idle >= 200) begin
            $display("no output was accepted for 200 cycles, run stopped");
            errors++;
        end
        if (seen_adef == 0 || seen_ine == 0) begin
            $display("random run produced no ADEF or no INE output");
            errors++;
        end
        $display("checked %0d outputs, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
src/fetch_pkg.sv
src/fetch_req.sv
src/inst_wait.sv
src/inst_decode.sv
src/fetch_frontend.sv
tests/tb_fetch_frontend.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f \
    --top-module tb_fetch_frontend -o sim_fetch
./obj_dir/sim_fetch | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished cleanly"
